// ==== list.f ====
+incdir+tb
source/rv_int_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/execute_stage.sv
source/int_pipe_top.sv
tb/tb_int_pipe.sv

// ==== Makefile ====
# Verilator build and run of the integer pipe testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_int_pipe -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_int_pipe); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== tb/tb_ref_model.svh ====
// Reference model of the integer pipe, instruction builders and xorshift, included by the testbench
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  // Kind of report expected for one cycle
  localparam logic [1:0] KIND_NONE = 2'd0;
  localparam logic [1:0] KIND_WB   = 2'd1;
  localparam logic [1:0] KIND_ILL  = 2'd2;

  // Architectural state
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;
  logic        model_halted;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] r_insn(input logic alt, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_int_pkg::REGREG};
  endfunction

  function automatic logic [31:0] i_insn(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_int_pkg::IMMED};
  endfunction

  function automatic logic [31:0] u_insn(input logic [6:0] op, input logic [19:0] imm,
                                         input logic [4:0] rd);
    return {imm, rd, op};
  endfunction

  // Arithmetic by funct3, alt set means SUB or arithmetic right shift
  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      rv_int_pkg::ADDSUB: return alt ? a - b : a + b;
      rv_int_pkg::SLL:    return a << sh;
      rv_int_pkg::SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_int_pkg::SLTU:   return (a < b) ? 32'd1 : 32'd0;
      rv_int_pkg::XOR:    return a ^ b;
      rv_int_pkg::SR: begin
        if (alt) begin
          return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
        end
        return a >> sh;
      end
      rv_int_pkg::OR:     return a | b;
      default:            return a & b;
    endcase
  endfunction

  // One accepted instruction against the architectural state
  task automatic model_step(input logic [31:0] instr, output logic [1:0] kind,
                            output logic [4:0] rd, output logic [31:0] data);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    op    = instr[6:0];
    f3    = instr[14:12];
    rd    = instr[11:7];
    a     = model_regs[instr[19:15]];
    b     = model_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_u = {instr[31:12], 12'b0};
    kind  = KIND_WB;
    data  = 32'b0;
    if (model_halted) begin
      kind = KIND_NONE;
    end else if (op == rv_int_pkg::REGREG) begin
      data = arith(f3, instr[30], a, b);
    end else if (op == rv_int_pkg::IMMED) begin
      data = arith(f3, instr[30] && (f3 == rv_int_pkg::SR), a, imm_i);
    end else if (op == rv_int_pkg::LUI) begin
      data = imm_u;
    end else if (op == rv_int_pkg::AUIPC) begin
      data = model_pc + imm_u;
    end else if (instr == rv_int_pkg::HALT_INSN) begin
      kind         = KIND_NONE;
      model_halted = 1'b1;
    end else begin
      kind = KIND_ILL;
    end
    // x0 still reports its value but keeps zero
    if (kind == KIND_WB && rd != 5'd0) begin
      model_regs[rd] = data;
    end
    model_pc = model_pc + 32'd4;
  endtask

`endif

// ==== tb/tb_int_pipe.sv ====
// Testbench for the integer pipe: random and directed instructions checked against a model
module tb_int_pipe;

  `include "tb_ref_model.svh"

  localparam logic [31:0] RESET_PC = 32'h0000_1000;

  // Expected outputs for one cycle, due at a given edge
  typedef struct packed {
    int          due;
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        halt;
  } expect_t;

  logic        CLK;
  logic        reset_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        illegal_o;
  logic        halt_o;

  int          edge_count;
  logic [31:0] rng_state;
  expect_t     exp_q[$];

  int_pipe_top #(.RESET_PC(RESET_PC)) dut0 (
    .CLK           (CLK),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o),
    .halt_o        (halt_o)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    edge_count = edge_count + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_bits(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_on_error($sformatf("[FAIL] time %0t %s expected %h actual %h",
                                   $time, name, exp, act));
  endtask

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Outputs are stable mid-cycle
  always @(negedge CLK) begin : check_outputs
    expect_t e;
    if (exp_q.size() > 0 && exp_q[0].due == edge_count) begin
      e = exp_q.pop_front();
      check_bits("wb_valid_o", {31'b0, e.kind == KIND_WB}, {31'b0, wb_valid_o});
      check_bits("illegal_o", {31'b0, e.kind == KIND_ILL}, {31'b0, illegal_o});
      check_bits("halt_o", {31'b0, e.halt}, {31'b0, halt_o});
      if (e.kind == KIND_WB) begin
        check_bits("wb_rd_o", {27'b0, e.rd}, {27'b0, wb_rd_o});
        check_bits("wb_data_o", e.data, wb_data_o);
      end
    end
  end

  // Drive one cycle; the report is due two edges after acceptance
  task automatic issue(input logic valid, input logic [31:0] instr);
    expect_t    e;
    logic [1:0] kind;
    logic [4:0] rd;
    logic [31:0] data;
    @(posedge CLK);
    #10;
    instr_valid_i = valid;
    instr_i       = instr;
    kind = KIND_NONE;
    rd   = 5'd0;
    data = 32'b0;
    if (valid) begin
      model_step(instr, kind, rd, data);
    end
    e.due  = edge_count + 2;
    e.kind = kind;
    e.rd   = rd;
    e.data = data;
    e.halt = model_halted;
    exp_q.push_back(e);
  endtask

  // Random bubble ahead of about one instruction in four
  task automatic send(input logic [31:0] instr);
    logic [31:0] r;
    r = next_random();
    if (r[1:0] == 2'b00) begin
      issue(1'b0, r);
    end
    issue(1'b1, instr);
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    int          waited;
    CLK           = 1'b0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = 32'b0;
    edge_count    = 0;
    rng_state     = 32'h9a57;
    model_pc      = RESET_PC;
    model_halted  = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'b0;
    end
    repeat (2) @(posedge CLK);
    #10;
    reset_i = 1'b0;

    // Fill x1..x31 with random values
    for (int i = 1; i < 32; i++) begin
      r = next_random();
      send(u_insn(rv_int_pkg::LUI, r[31:12], i[4:0]));
      send(i_insn(r[11:0], i[4:0], rv_int_pkg::ADDSUB, i[4:0]));
    end

    // Register forms, every funct3 with and without bit 30
    for (int i = 0; i < 96; i++) begin
      r   = next_random();
      f3  = i[2:0];
      alt = i[3] && (f3 == rv_int_pkg::ADDSUB || f3 == rv_int_pkg::SR);
      send(r_insn(alt, r[4:0], r[9:5], f3, r[14:10]));
    end

    // Immediate forms, shifts take a 5-bit amount
    for (int i = 0; i < 96; i++) begin
      r  = next_random();
      f3 = i[2:0];
      if (f3 == rv_int_pkg::SLL || f3 == rv_int_pkg::SR) begin
        imm = {1'b0, i[3] && (f3 == rv_int_pkg::SR), 5'b0, r[24:20]};
      end else begin
        imm = r[31:20];
      end
      send(i_insn(imm, r[9:5], f3, r[14:10]));
    end

    // Edge values on a negative operand in x5
    send(u_insn(rv_int_pkg::LUI, 20'h80000, 5'd5));
    send(i_insn(12'hfff, 5'd5, rv_int_pkg::SLT, 5'd6));
    send(i_insn(12'h800, 5'd5, rv_int_pkg::SLT, 5'd7));
    send(i_insn(12'hfff, 5'd5, rv_int_pkg::SLTU, 5'd8));
    send(i_insn(12'h7ff, 5'd0, rv_int_pkg::SLTU, 5'd9));
    send(i_insn(12'h41f, 5'd5, rv_int_pkg::SR, 5'd10));
    send(i_insn(12'h01f, 5'd5, rv_int_pkg::SR, 5'd11));
    send(i_insn(12'h01f, 5'd4, rv_int_pkg::SLL, 5'd12));

    // LUI and AUIPC, pc counted by the model
    for (int i = 0; i < 16; i++) begin
      r = next_random();
      send(u_insn(i[0] ? rv_int_pkg::AUIPC : rv_int_pkg::LUI, r[31:12], r[4:0]));
    end

    // Dependent chain through x10
    for (int i = 0; i < 24; i++) begin
      r = next_random();
      if (i[0]) begin
        send(r_insn(r[30], r[9:5], 5'd10, r[2:0], 5'd10));
      end else begin
        send(i_insn(r[31:20], 5'd10, r[2:0], 5'd10));
      end
    end

    // x0 reports its value, then reads back as zero
    send(i_insn(12'h123, 5'd1, rv_int_pkg::ADDSUB, 5'd0));
    send(r_insn(1'b0, 5'd0, 5'd0, rv_int_pkg::ADDSUB, 5'd13));

    // Unsupported opcodes aimed at x3, which must stay unchanged
    r = next_random();
    send({r[31:12], 5'd3, rv_int_pkg::JAL});
    send({r[31:12], 5'd3, rv_int_pkg::JALR});
    send({r[31:12], 5'd3, rv_int_pkg::BRANCH});
    send({r[31:12], 5'd3, rv_int_pkg::LOAD});
    send({r[31:12], 5'd3, rv_int_pkg::STORE});
    send({r[31:12], 5'd3, rv_int_pkg::SYSTEM});
    send(32'h0000_0073);
    send(r_insn(1'b0, 5'd0, 5'd3, rv_int_pkg::ADDSUB, 5'd14));

    // Halt, then 20 cycles of traffic that must be ignored
    send(rv_int_pkg::HALT_INSN);
    for (int i = 0; i < 20; i++) begin
      r = next_random();
      issue(1'b1, i[0] ? r : r_insn(1'b0, r[4:0], r[9:5], r[14:12], r[19:15]));
    end
    issue(1'b0, 32'b0);

    waited = 0;
    while (exp_q.size() > 0 && waited < 8) begin
      @(posedge CLK);
      waited++;
    end
    if (exp_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_on_error("Timeout: expected reports were still pending after the last instruction");
    end
  end

endmodule

// ==== source/int_pipe_top.sv ====
// Top of the RV32I integer pipe; holds the pc and ties decode, execute and register file together
module int_pipe_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                              CLK,
  input  logic                              reset_i,
  input  logic                              instr_valid_i,
  input  logic [31:0]                       instr_i,
  output logic                              wb_valid_o,
  output logic [rv_int_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [31:0]                       wb_data_o,
  output logic                              illegal_o,
  output logic                              halt_o
);

  logic [31:0]                       pc_q;

  logic                              dec_valid;
  logic [31:0]                       dec_pc;
  logic [rv_int_pkg::REG_ADDR_W-1:0] dec_rs1;
  logic [rv_int_pkg::REG_ADDR_W-1:0] dec_rs2;
  logic [rv_int_pkg::REG_ADDR_W-1:0] dec_rd;
  logic [31:0]                       dec_imm_i;
  logic [31:0]                       dec_imm_u;
  rv_int_pkg::alu_op_t               dec_alu_op;
  rv_int_pkg::a_sel_t                dec_a_sel;
  rv_int_pkg::b_sel_t                dec_b_sel;
  logic                              dec_wen;
  logic                              dec_illegal;
  logic                              dec_halt;

  logic [31:0]                       rs1_data;
  logic [31:0]                       rs2_data;
  logic                              rf_we;
  logic [rv_int_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [31:0]                       rf_wdata;

  // pc of the next instruction to be accepted
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else if (instr_valid_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  instr_decoder u_decoder (
    .CLK       (CLK),
    .reset_i   (reset_i),
    .valid_i   (instr_valid_i),
    .instr_i   (instr_i),
    .pc_i      (pc_q),
    .valid_o   (dec_valid),
    .pc_o      (dec_pc),
    .rs1_o     (dec_rs1),
    .rs2_o     (dec_rs2),
    .rd_o      (dec_rd),
    .imm_i_o   (dec_imm_i),
    .imm_u_o   (dec_imm_u),
    .alu_op_o  (dec_alu_op),
    .a_sel_o   (dec_a_sel),
    .b_sel_o   (dec_b_sel),
    .wen_o     (dec_wen),
    .illegal_o (dec_illegal),
    .halt_o    (dec_halt)
  );

  // Read ports follow the registered indices, so execute reads during its own cycle
  reg_file u_reg_file (
    .CLK      (CLK),
    .reset_i  (reset_i),
    .raddr1_i (dec_rs1),
    .raddr2_i (dec_rs2),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  execute_stage u_execute (
    .CLK        (CLK),
    .reset_i    (reset_i),
    .valid_i    (dec_valid),
    .pc_i       (dec_pc),
    .rd_i       (dec_rd),
    .imm_i_i    (dec_imm_i),
    .imm_u_i    (dec_imm_u),
    .alu_op_i   (dec_alu_op),
    .a_sel_i    (dec_a_sel),
    .b_sel_i    (dec_b_sel),
    .wen_i      (dec_wen),
    .illegal_i  (dec_illegal),
    .halt_i     (dec_halt),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o),
    .illegal_o  (illegal_o),
    .halt_o     (halt_o)
  );

endmodule

// ==== source/execute_stage.sv ====
// Execute stage of the integer pipe; runs the ALU, writes the register file and reports writeback
module execute_stage (
  input  logic                              CLK,
  input  logic                              reset_i,
  input  logic                              valid_i,
  input  logic [31:0]                       pc_i,
  input  logic [rv_int_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [31:0]                       imm_i_i,
  input  logic [31:0]                       imm_u_i,
  input  rv_int_pkg::alu_op_t               alu_op_i,
  input  rv_int_pkg::a_sel_t                a_sel_i,
  input  rv_int_pkg::b_sel_t                b_sel_i,
  input  logic                              wen_i,
  input  logic                              illegal_i,
  input  logic                              halt_i,
  input  logic [31:0]                       rs1_data_i,
  input  logic [31:0]                       rs2_data_i,
  output logic                              rf_we_o,
  output logic [rv_int_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [31:0]                       rf_wdata_o,
  output logic                              wb_valid_o,
  output logic [rv_int_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [31:0]                       wb_data_o,
  output logic                              illegal_o,
  output logic                              halt_o
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic [31:0] alu_res;
  logic        accept;

  // Nothing gets through once halted
  assign accept = valid_i && !halt_o;

  // Operand A, zero base for LUI
  always_comb begin
    if (b_sel_i == rv_int_pkg::B_ZERO) begin
      op_a = 32'b0;
    end else if (a_sel_i == rv_int_pkg::A_PC) begin
      op_a = pc_i;
    end else begin
      op_a = rs1_data_i;
    end
  end

  always_comb begin
    case (b_sel_i)
      rv_int_pkg::B_RS2:   op_b = rs2_data_i;
      rv_int_pkg::B_IMM_I: op_b = imm_i_i;
      default:             op_b = imm_u_i;
    endcase
  end

  assign shamt = op_b[4:0];

  // ALU
  always_comb begin
    case (alu_op_i)
      rv_int_pkg::ALU_ADD:  alu_res = op_a + op_b;
      rv_int_pkg::ALU_SUB:  alu_res = op_a - op_b;
      rv_int_pkg::ALU_SLL:  alu_res = op_a << shamt;
      rv_int_pkg::ALU_SRL:  alu_res = op_a >> shamt;
      rv_int_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
      rv_int_pkg::ALU_AND:  alu_res = op_a & op_b;
      rv_int_pkg::ALU_OR:   alu_res = op_a | op_b;
      rv_int_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      rv_int_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_int_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      default:              alu_res = 32'b0;
    endcase
  end

  // Write lands on the edge that ends execute, so the next instruction reads it
  // Illegal and halt instructions never carry wen from decode
  assign rf_we_o    = accept && wen_i;
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = alu_res;

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      wb_valid_o <= 1'b0;
      illegal_o  <= 1'b0;
      halt_o     <= 1'b0;
    end else begin
      wb_valid_o <= rf_we_o;
      illegal_o  <= accept && illegal_i;
      // Sticky until reset
      halt_o     <= halt_o || (accept && halt_i);
    end
  end

  // Report payload, x0 writes still show their value
  always_ff @(posedge CLK) begin
    if (rf_we_o) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= alu_res;
    end
  end

endmodule

// ==== source/reg_file.sv ====
// Integer register file for the pipe: two combinational reads, one clocked write, x0 reads as zero
module reg_file (
  input  logic                              CLK,
  input  logic                              reset_i,
  input  logic [rv_int_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [rv_int_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [31:0]                       rdata1_o,
  output logic [31:0]                       rdata2_o,
  input  logic                              we_i,
  input  logic [rv_int_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [31:0]                       wdata_i
);

  localparam int NUM_REGS = 2 ** rv_int_pkg::REG_ADDR_W;

  logic [31:0] regs [NUM_REGS];

  // Writes to x0 are dropped
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 hardwired
  assign rdata1_o = (raddr1_i == '0) ? 32'b0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? 32'b0 : regs[raddr2_i];

endmodule

// ==== source/instr_decoder.sv ====
// Decode stage of the integer pipe; splits one instruction into fields and registers its control word
module instr_decoder (
  input  logic                              CLK,
  input  logic                              reset_i,
  input  logic                              valid_i,
  input  logic [31:0]                       instr_i,
  input  logic [31:0]                       pc_i,
  output logic                              valid_o,
  output logic [31:0]                       pc_o,
  output logic [rv_int_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_int_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv_int_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [31:0]                       imm_i_o,
  output logic [31:0]                       imm_u_o,
  output rv_int_pkg::alu_op_t               alu_op_o,
  output rv_int_pkg::a_sel_t                a_sel_o,
  output rv_int_pkg::b_sel_t                b_sel_o,
  output logic                              wen_o,
  output logic                              illegal_o,
  output logic                              halt_o
);

  rv_int_pkg::opcode_t                opcode;
  logic [2:0]                         funct3;
  logic                               alt;
  logic [rv_int_pkg::REG_ADDR_W-1:0]  rs1_f;
  logic [rv_int_pkg::REG_ADDR_W-1:0]  rs2_f;
  logic [rv_int_pkg::REG_ADDR_W-1:0]  rd_f;
  logic [31:0]                        imm_i_f;
  logic [31:0]                        imm_u_f;

  rv_int_pkg::alu_op_t                nxt_alu_op;
  rv_int_pkg::a_sel_t                 nxt_a_sel;
  rv_int_pkg::b_sel_t                 nxt_b_sel;
  logic                               nxt_wen;
  logic                               nxt_illegal;
  logic                               nxt_halt;

  // Map funct3 to an ALU operation
  // alt is instruction bit 30; SUB only exists in the register form
  function automatic rv_int_pkg::alu_op_t funct3_to_alu(input logic [2:0] f3,
                                                        input logic       alt_bit,
                                                        input logic       is_reg);
    rv_int_pkg::alu_op_t op;
    case (f3)
      rv_int_pkg::ADDSUB: op = (is_reg && alt_bit) ? rv_int_pkg::ALU_SUB : rv_int_pkg::ALU_ADD;
      rv_int_pkg::SLL:    op = rv_int_pkg::ALU_SLL;
      rv_int_pkg::SLT:    op = rv_int_pkg::ALU_SLT;
      rv_int_pkg::SLTU:   op = rv_int_pkg::ALU_SLTU;
      rv_int_pkg::XOR:    op = rv_int_pkg::ALU_XOR;
      rv_int_pkg::SR:     op = alt_bit ? rv_int_pkg::ALU_SRA : rv_int_pkg::ALU_SRL;
      rv_int_pkg::OR:     op = rv_int_pkg::ALU_OR;
      default:            op = rv_int_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // Instruction fields
  assign opcode  = rv_int_pkg::opcode_t'(instr_i[6:0]);
  assign funct3  = instr_i[14:12];
  assign alt     = instr_i[30];
  assign rd_f    = instr_i[11:7];
  assign rs1_f   = instr_i[19:15];
  assign rs2_f   = instr_i[24:20];

  // Immediates; shift amount sits in the low 5 bits of the I immediate
  assign imm_i_f = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_f = {instr_i[31:12], 12'b0};

  // One decision per opcode
  always_comb begin
    nxt_alu_op  = rv_int_pkg::ALU_ADD;
    nxt_a_sel   = rv_int_pkg::A_RS1;
    nxt_b_sel   = rv_int_pkg::B_RS2;
    nxt_wen     = 1'b0;
    nxt_illegal = 1'b0;
    nxt_halt    = 1'b0;
    case (opcode)
      rv_int_pkg::REGREG: begin
        nxt_alu_op = funct3_to_alu(funct3, alt, 1'b1);
        nxt_wen    = 1'b1;
      end
      rv_int_pkg::IMMED: begin
        nxt_alu_op = funct3_to_alu(funct3, alt, 1'b0);
        nxt_b_sel  = rv_int_pkg::B_IMM_I;
        nxt_wen    = 1'b1;
      end
      rv_int_pkg::LUI: begin
        nxt_b_sel = rv_int_pkg::B_ZERO;
        nxt_wen   = 1'b1;
      end
      rv_int_pkg::AUIPC: begin
        nxt_a_sel = rv_int_pkg::A_PC;
        nxt_b_sel = rv_int_pkg::B_IMM_U;
        nxt_wen   = 1'b1;
      end
      rv_int_pkg::SYSTEM: begin
        // Only EBREAK is understood, and it stops the core
        if (instr_i == rv_int_pkg::HALT_INSN) begin
          nxt_halt = 1'b1;
        end else begin
          nxt_illegal = 1'b1;
        end
      end
      default: begin
        nxt_illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Control word, loaded only for an accepted instruction
  always_ff @(posedge CLK) begin
    if (valid_i) begin
      pc_o      <= pc_i;
      rs1_o     <= rs1_f;
      rs2_o     <= rs2_f;
      rd_o      <= rd_f;
      imm_i_o   <= imm_i_f;
      imm_u_o   <= imm_u_f;
      alu_op_o  <= nxt_alu_op;
      a_sel_o   <= nxt_a_sel;
      b_sel_o   <= nxt_b_sel;
      wen_o     <= nxt_wen;
      illegal_o <= nxt_illegal;
      halt_o    <= nxt_halt;
    end
  end

endmodule

// ==== source/rv_int_pkg.sv ====
// Shared RV32I encodings, ALU operations and operand selects, used by scoped name across the pipe
package rv_int_pkg;

  // Width of a register index
  localparam int REG_ADDR_W = 5;

  // EBREAK, used by the core as its halt pattern
  localparam logic [31:0] HALT_INSN = 32'h0010_0073;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    REGREG = 7'b0110011,
    IMMED  = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_t;

  // funct3 codes, same values for R-type and I-type arithmetic
  localparam logic [2:0] ADDSUB = 3'b000;
  localparam logic [2:0] SLL    = 3'b001;
  localparam logic [2:0] SLT    = 3'b010;
  localparam logic [2:0] SLTU   = 3'b011;
  localparam logic [2:0] XOR    = 3'b100;
  // Shift right, bit 30 picks arithmetic
  localparam logic [2:0] SR     = 3'b101;
  localparam logic [2:0] OR     = 3'b110;
  localparam logic [2:0] AND    = 3'b111;

  // ALU operations carried from decode to execute
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Operand A source
  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_sel_t;

  // Operand B source
  // B_ZERO is the LUI form: U immediate on a zero base
  typedef enum logic [1:0] {
    B_RS2   = 2'd0,
    B_IMM_I = 2'd1,
    B_IMM_U = 2'd2,
    B_ZERO  = 2'd3
  } b_sel_t;

endpackage
